//--- div_pkg.sv
// divide unit shared definitions
`default_nettype none

package div_pkg;

  // ==========================================================================
  // data types
  // ==========================================================================
  typedef logic [63:0]  xlen_t;   // one data word
  typedef logic [127:0] wide_t;   // remainder:quotient working register
  typedef logic [7:0]   div_op_t; // one-hot operation code
  typedef logic [6:0]   step_t;   // iteration counter

  // ==========================================================================
  // operation codes, one-hot
  // ==========================================================================
  localparam div_op_t OP_REM     = 8'b1000_0000; // signed 64
  localparam div_op_t OP_REMU    = 8'b0100_0000;
  localparam div_op_t OP_REMUW   = 8'b0010_0000;
  localparam div_op_t OP_REMW    = 8'b0001_0000;
  localparam div_op_t OP_DIV     = 8'b0000_1000;
  localparam div_op_t OP_DIVU    = 8'b0000_0100;
  localparam div_op_t OP_DIVUW   = 8'b0000_0010;
  localparam div_op_t OP_DIVW    = 8'b0000_0001;
  localparam div_op_t OP_SPECIAL = 8'b0000_0000; // stored special value

  // iteration counts
  localparam step_t STEPS_D = 7'd64;
  localparam step_t STEPS_W = 7'd32;

  typedef enum logic [1:0] {
    S_IDLE,
    S_DIV,
    S_FINISH
  } div_state_e;

  // op class decode, shared by prep and output select
  function automatic logic op_is_word(div_op_t op);
    return |(op & (OP_REMUW | OP_REMW | OP_DIVUW | OP_DIVW));
  endfunction

  function automatic logic op_is_signed(div_op_t op);
    return |(op & (OP_REM | OP_REMW | OP_DIV | OP_DIVW));
  endfunction

  function automatic logic op_is_rem(div_op_t op);
    return |(op & (OP_REM | OP_REMU | OP_REMUW | OP_REMW));
  endfunction

endpackage

`default_nettype wire

//--- div_if.sv
// divide unit internal interfaces
`timescale 1ns/1ps
`default_nettype none

// ============================================================================
// prepared request, prep -> core
// ============================================================================
interface div_req_if ();
  import div_pkg::*;

  div_op_t op;       // OP_SPECIAL when special
  xlen_t   dvd;      // initial low half of acc
  xlen_t   dvs;      // divisor magnitude
  step_t   steps;
  logic    q_neg;    // negate quotient at the end
  logic    r_neg;    // negate remainder at the end
  logic    special;  // zero divisor or signed overflow
  xlen_t   spec_val;

  modport prep (
    output op,
    output dvd,
    output dvs,
    output steps,
    output q_neg,
    output r_neg,
    output special,
    output spec_val
  );

  modport core (
    input op,
    input dvd,
    input dvs,
    input steps,
    input q_neg,
    input r_neg,
    input special,
    input spec_val
  );
endinterface

// ============================================================================
// latched state, core -> output select
// ============================================================================
interface div_res_if ();
  import div_pkg::*;

  div_op_t op;
  wide_t   acc;    // remainder 127:64, quotient 63:0
  logic    q_neg;
  logic    r_neg;

  modport core (output op, output acc, output q_neg, output r_neg);
  modport sel  (input op, input acc, input q_neg, input r_neg);
endinterface

`default_nettype wire

//--- div_prep.sv
// divide operand preparation
`timescale 1ns/1ps
`default_nettype none

module div_prep (
  input  div_pkg::div_op_t div_type_i,
  input  div_pkg::xlen_t   dividend_i,
  input  div_pkg::xlen_t   divisor_i,
  div_req_if.prep          req
);
  import div_pkg::*;

  logic  is_word;
  logic  is_signed;
  logic  is_rem;
  xlen_t dvd_sx;     // 32 -> 64 sign extensions
  xlen_t dvs_sx;
  xlen_t dvd_ext;    // operands as seen by this op
  xlen_t dvs_ext;
  logic  dvd_sign;
  logic  dvs_sign;
  xlen_t dvd_abs;
  xlen_t dvs_abs;
  xlen_t dvd_res;    // dividend as an architectural result
  logic  div_zero;
  logic  sgn_ovf;
  xlen_t spec_val;

  assign is_word   = op_is_word(div_type_i);
  assign is_signed = op_is_signed(div_type_i);
  assign is_rem    = op_is_rem(div_type_i);

  // ==========================================================================
  // operand forms and magnitudes
  // ==========================================================================
  assign dvd_sx = {{32{dividend_i[31]}}, dividend_i[31:0]};
  assign dvs_sx = {{32{divisor_i[31]}}, divisor_i[31:0]};

  always_comb begin
    if (!is_word) begin
      dvd_ext = dividend_i;
      dvs_ext = divisor_i;
    end else if (is_signed) begin
      dvd_ext = dvd_sx;
      dvs_ext = dvs_sx;
    end else begin
      dvd_ext = {32'b0, dividend_i[31:0]}; // unsigned word, zero extend
      dvs_ext = {32'b0, divisor_i[31:0]};
    end
  end

  assign dvd_sign = is_signed & dvd_ext[63];
  assign dvs_sign = is_signed & dvs_ext[63];

  assign dvd_abs = dvd_sign ? -dvd_ext : dvd_ext;
  assign dvs_abs = dvs_sign ? -dvs_ext : dvs_ext;

  // ==========================================================================
  // zero divisor and signed overflow
  // ==========================================================================
  assign div_zero = is_word ? ~|divisor_i[31:0] : ~|divisor_i;

  always_comb begin
    if (!is_signed)
      sgn_ovf = 1'b0;
    else if (is_word)
      sgn_ovf = (dividend_i[31:0] == 32'h8000_0000) && (&divisor_i[31:0]);
    else
      sgn_ovf = (dividend_i == 64'h8000_0000_0000_0000) && (&divisor_i);
  end

  // word results always come back sign extended
  assign dvd_res = is_word ? dvd_sx : dividend_i;

  always_comb begin
    if (div_zero)
      spec_val = is_rem ? dvd_res : '1; // quotient all ones
    else if (sgn_ovf)
      spec_val = is_rem ? '0 : dvd_res;
    else
      spec_val = '0;
  end

  // ==========================================================================
  // request out
  // ==========================================================================
  assign req.special  = div_zero | sgn_ovf;
  assign req.op       = req.special ? OP_SPECIAL : div_type_i;
  assign req.dvd      = is_word ? {dvd_abs[31:0], 32'b0} : dvd_abs; // word in upper half
  assign req.dvs      = dvs_abs;
  assign req.steps    = is_word ? STEPS_W : STEPS_D;
  assign req.q_neg    = dvd_sign ^ dvs_sign;
  assign req.r_neg    = dvd_sign;          // remainder follows dividend
  assign req.spec_val = spec_val;

endmodule

`default_nettype wire

//--- div_core.sv
// restoring divide iteration FSM
`timescale 1ns/1ps
`default_nettype none

module div_core (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    div_valid_i,
  input  logic    result_ready_i,
  div_req_if.core req,
  div_res_if.core res,
  output logic    div_stall_o,
  output logic    result_ok_o
);
  import div_pkg::*;

  div_state_e  state_q;
  div_state_e  state_d;
  step_t       cnt_q;
  div_op_t     op_q;
  logic        q_neg_q;
  logic        r_neg_q;
  wide_t       acc_q;     // remainder:quotient
  xlen_t       dvs_q;
  logic [64:0] diff;      // trial subtract, bit 64 is the borrow
  logic        start;
  logic        release_res;

  assign start       = (state_q == S_IDLE) && div_valid_i;
  assign release_res = (state_q == S_FINISH) && result_ready_i;

  // ==========================================================================
  // state machine
  // ==========================================================================
  always_comb begin
    case (state_q)
      S_IDLE:   state_d = start ? (req.special ? S_FINISH : S_DIV) : S_IDLE;
      S_DIV:    state_d = (cnt_q == '0) ? S_FINISH : S_DIV;
      S_FINISH: state_d = result_ready_i ? S_IDLE : S_FINISH;
      default:  state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n)
      state_q <= S_IDLE;
    else
      state_q <= state_d;
  end

  // latched op, flags and step count
  always_ff @(posedge clk) begin
    if (rst_n) begin
      cnt_q   <= '0;
      op_q    <= OP_SPECIAL;
      q_neg_q <= 1'b0;
      r_neg_q <= 1'b0;
    end else if (start) begin
      cnt_q   <= req.special ? '0 : req.steps;
      op_q    <= req.op;
      q_neg_q <= req.q_neg & ~req.special;
      r_neg_q <= req.r_neg & ~req.special;
    end else if (state_q == S_DIV && cnt_q != '0) begin
      cnt_q   <= cnt_q - 7'd1;
    end else if (release_res) begin
      cnt_q   <= '0;
      op_q    <= OP_SPECIAL;
      q_neg_q <= 1'b0;
      r_neg_q <= 1'b0;
    end
  end

  // ==========================================================================
  // shift-subtract datapath
  // ==========================================================================
  assign diff = acc_q[127:63] - {1'b0, dvs_q}; // shifted remainder minus divisor

  always_ff @(posedge clk) begin
    if (start) begin
      acc_q <= {64'b0, (req.special ? req.spec_val : req.dvd)};
      dvs_q <= req.dvs;
    end else if (state_q == S_DIV && cnt_q != '0) begin
      if (diff[64])
        acc_q <= {acc_q[126:0], 1'b0};              // restore
      else
        acc_q <= {diff[63:0], acc_q[62:0], 1'b1};   // keep difference
    end else if (release_res) begin
      acc_q <= '0;
    end
  end

  // ==========================================================================
  // outputs
  // ==========================================================================
  assign res.op    = op_q;
  assign res.acc   = acc_q;
  assign res.q_neg = q_neg_q;
  assign res.r_neg = r_neg_q;

  assign result_ok_o = (state_q == S_FINISH);
  assign div_stall_o = (start && !req.special) || (state_q == S_DIV); // busy

endmodule

`default_nettype wire

//--- div_result_sel.sv
// divide result select and sign fix
`timescale 1ns/1ps
`default_nettype none

module div_result_sel (
  div_res_if.sel          res,
  output div_pkg::xlen_t  div_out_o
);
  import div_pkg::*;

  logic  is_word;
  logic  is_rem;
  xlen_t quo;
  xlen_t rem;
  xlen_t quo_fix;   // sign corrected
  xlen_t rem_fix;
  xlen_t picked;

  assign is_word = op_is_word(res.op);
  assign is_rem  = op_is_rem(res.op);

  assign quo = res.acc[63:0];
  assign rem = res.acc[127:64];

  // magnitudes back to signed results
  assign quo_fix = res.q_neg ? -quo : quo;
  assign rem_fix = res.r_neg ? -rem : rem;

  assign picked = is_rem ? rem_fix : quo_fix;

  always_comb begin
    if (res.op == OP_SPECIAL)
      div_out_o = quo;                              // stored special value
    else if (is_word)
      div_out_o = {{32{picked[31]}}, picked[31:0]}; // word ops sign extend
    else
      div_out_o = picked;
  end

endmodule

`default_nettype wire

//--- div_unit.sv
// RV64 M extension divide unit
`timescale 1ns/1ps
`default_nettype none

module div_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             div_valid_i,
  input  div_pkg::div_op_t div_type_i,
  input  div_pkg::xlen_t   dividend_i,
  input  div_pkg::xlen_t   divisor_i,
  input  logic             result_ready_i,
  output div_pkg::xlen_t   div_out_o,
  output logic             div_stall_o,
  output logic             result_ok_o
);

  div_req_if u_req_if ();
  div_res_if u_res_if ();

  // ==========================================================================
  // operand prep, combinational
  // ==========================================================================
  div_prep u_prep (
    .div_type_i (div_type_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .req        (u_req_if.prep)
  );

  // iteration FSM
  div_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .result_ready_i (result_ready_i),
    .req            (u_req_if.core),
    .res            (u_res_if.core),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

  // output select, combinational
  div_result_sel u_result_sel (
    .res       (u_res_if.sel),
    .div_out_o (div_out_o)
  );

endmodule

`default_nettype wire

//--- div_unit_chk.sv
// divide unit protocol checks
`timescale 1ns/1ps
`default_nettype none

module div_unit_chk (
  input logic           clk,
  input logic           rst_n,
  input logic           result_ready_i,
  input logic           div_stall_o,
  input logic           result_ok_o,
  input div_pkg::xlen_t div_out_o
);

  int fail_cnt = 0;  // read by the testbench at the end of the run

  // quiet in the first cycle out of reset
  a_reset_quiet: assert property (@(posedge clk)
    $fell(rst_n) |-> (!result_ok_o && !div_stall_o))
    else begin
      $error("result_ok_o or div_stall_o high in the first cycle after reset");
      fail_cnt++;
    end

  a_ok_not_busy: assert property (@(posedge clk) disable iff (rst_n)
    !(result_ok_o && div_stall_o))
    else begin
      $error("result_ok_o and div_stall_o high together");
      fail_cnt++;
    end

  // back-pressure holds the result
  a_out_stable: assert property (@(posedge clk) disable iff (rst_n)
    (result_ok_o && !result_ready_i) |=> $stable(div_out_o))
    else begin
      $error("div_out_o changed while the result was held");
      fail_cnt++;
    end

  a_ok_held: assert property (@(posedge clk) disable iff (rst_n)
    (result_ok_o && !result_ready_i) |=> result_ok_o)
    else begin
      $error("result_ok_o dropped before result_ready_i");
      fail_cnt++;
    end

endmodule

bind div_unit div_unit_chk u_chk (
  .clk            (clk),
  .rst_n          (rst_n),
  .result_ready_i (result_ready_i),
  .div_stall_o    (div_stall_o),
  .result_ok_o    (result_ok_o),
  .div_out_o      (div_out_o)
);

`default_nettype wire

//--- div_unit_tb.sv
// divide unit testbench
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;
  import div_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int RST_CYCLES      = 8;
  localparam int N_D             = 24;  // random 64-bit ops
  localparam int N_W             = 24;  // random word ops
  localparam int N_BP            = 12;  // back-pressure ops
  localparam int TOTAL_OPS       = N_D + N_W + 8 + 4 + N_BP + 2;
  localparam int RESULT_TIMEOUT  = 100;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 80 + 200;

  logic    clk;
  logic    rst_n;
  logic    div_valid_i;
  div_op_t div_type_i;
  xlen_t   dividend_i;
  xlen_t   divisor_i;
  logic    result_ready_i;
  xlen_t   div_out_o;
  logic    div_stall_o;
  logic    result_ok_o;

  xlen_t   drv_exp;       // expected values of the request on the inputs
  int      drv_rise;
  logic    drv_special;
  logic    busy;          // protocol model latched at acceptance
  int      lat_cnt;
  xlen_t   exp_val;
  int      exp_rise;      // edge after which result_ok_o rises
  logic    exp_special;
  int      err_cnt = 0;
  int      timeout_cnt = 0;
  int      op_cnt = 0;
  int      test_cnt = 0;

  div_unit u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_type_i     (div_type_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .div_out_o      (div_out_o),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // accepts only in idle and releases when the result is taken
  always @(posedge clk) begin
    if (rst_n) begin
      busy        <= 1'b0;
      lat_cnt     <= 0;
      exp_val     <= '0;
      exp_rise    <= 0;
      exp_special <= 1'b0;
    end else if (!busy && div_valid_i) begin
      busy        <= 1'b1;
      lat_cnt     <= 0;
      exp_val     <= drv_exp;
      exp_rise    <= drv_rise;
      exp_special <= drv_special;
    end else if (busy) begin
      lat_cnt <= lat_cnt + 1;
      if (result_ok_o && result_ready_i)
        busy <= 1'b0;
    end
  end

  // ==========================================================================
  // result and timing checks
  // ==========================================================================
  a_result: assert property (@(posedge clk) disable iff (rst_n)
    (result_ok_o && result_ready_i) |-> (div_out_o == exp_val))
    else begin
      $display("ERROR time %0t div_out_o got %h expected %h",
               $time, $sampled(div_out_o), $sampled(exp_val));
      err_cnt++;
    end

  a_rise: assert property (@(posedge clk) disable iff (rst_n)
    $rose(result_ok_o) |-> (busy && lat_cnt == exp_rise))
    else begin
      $display("ERROR time %0t result_ok_o rise cycle got %0d expected %0d",
               $time, $sampled(lat_cnt), $sampled(exp_rise));
      err_cnt++;
    end

  a_idle_quiet: assert property (@(posedge clk) disable iff (rst_n)
    !busy |-> !result_ok_o)
    else begin
      $display("ERROR time %0t result_ok_o got 1 expected 0", $time);
      err_cnt++;
    end

  a_stall_start: assert property (@(posedge clk) disable iff (rst_n)
    (!busy && div_valid_i) |-> (div_stall_o == !drv_special))
    else begin
      $display("ERROR time %0t div_stall_o got %b expected %b",
               $time, $sampled(div_stall_o), $sampled(!drv_special));
      err_cnt++;
    end

  // high through the last iteration cycle of a normal division
  a_stall_busy: assert property (@(posedge clk) disable iff (rst_n)
    busy |-> (div_stall_o == (!exp_special && lat_cnt < exp_rise)))
    else begin
      $display("ERROR time %0t div_stall_o got %b expected %b", $time,
               $sampled(div_stall_o), $sampled(!exp_special && lat_cnt < exp_rise));
      err_cnt++;
    end

  // ==========================================================================
  // helpers
  // ==========================================================================
  function automatic int error_total();
    return err_cnt + timeout_cnt + u_dut.u_chk.fail_cnt;
  endfunction

  function automatic div_op_t pick_op(input int idx);
    case (idx)
      0:       return OP_DIV;
      1:       return OP_DIVU;
      2:       return OP_REM;
      3:       return OP_REMU;
      4:       return OP_DIVW;
      5:       return OP_DIVUW;
      6:       return OP_REMW;
      default: return OP_REMUW;
    endcase
  endfunction

  // random operand with garbage kept above bit 31 for word forms
  function automatic xlen_t rand_operand(input logic word);
    xlen_t       v;
    logic [31:0] lo;
    v  = {$urandom, $urandom};
    lo = $urandom;
    case ($urandom % 4)
      0: begin
        v  = v >> ($urandom % 60);
        lo = lo >> ($urandom % 28);
      end
      1: begin
        v  = -(v >> ($urandom % 60));  // small negative
        lo = -(lo >> ($urandom % 28));
      end
      default: ;
    endcase
    return word ? {v[63:32], lo} : v;
  endfunction

  // reference model by the RISC-V M division rules
  task automatic calc_expected(input div_op_t op, input xlen_t a, input xlen_t b,
                               output xlen_t val, output int rise, output logic special);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic [31:0]        wr;
    logic               word;
    logic               zero;
    logic               ovf;
    sa   = a;
    sb   = b;
    wa   = a[31:0];
    wb   = b[31:0];
    word = (op == OP_DIVW) || (op == OP_DIVUW) || (op == OP_REMW) || (op == OP_REMUW);
    zero = word ? (b[31:0] == 32'd0) : (b == 64'd0);
    ovf  = 1'b0;
    val  = '0;
    wr   = '0;
    case (op)
      OP_DIV: begin
        ovf = (a == 64'h8000_0000_0000_0000) && (&b);
        if (zero)
          val = '1;
        else if (ovf)
          val = a;
        else
          val = sa / sb;
      end
      OP_REM: begin
        ovf = (a == 64'h8000_0000_0000_0000) && (&b);
        if (zero)
          val = a;
        else if (ovf)
          val = '0;
        else
          val = sa % sb;
      end
      OP_DIVU: val = zero ? '1 : a / b;
      OP_REMU: val = zero ? a : a % b;
      OP_DIVW: begin
        ovf = (a[31:0] == 32'h8000_0000) && (&b[31:0]);
        if (zero)
          wr = '1;
        else if (ovf)
          wr = a[31:0];
        else
          wr = wa / wb;
      end
      OP_REMW: begin
        ovf = (a[31:0] == 32'h8000_0000) && (&b[31:0]);
        if (zero)
          wr = a[31:0];
        else if (ovf)
          wr = '0;
        else
          wr = wa % wb;
      end
      OP_DIVUW: wr = zero ? '1 : a[31:0] / b[31:0];
      OP_REMUW: wr = zero ? a[31:0] : a[31:0] % b[31:0];
      default:  val = '0;
    endcase
    if (word)
      val = {{32{wr[31]}}, wr};
    special = zero || ovf;
    rise    = special ? 0 : (word ? 33 : 65);  // steps plus one
  endtask

  task automatic apply_reset();
    rst_n          = 1'b1;
    div_valid_i    = 1'b0;
    result_ready_i = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b0;
    @(posedge clk);  // first cycle out of reset stays quiet
    #1;
  endtask

  // drives one request and takes its result after hold cycles
  task automatic run_op(input div_op_t op, input xlen_t a, input xlen_t b,
                        input int hold, input logic poke_busy);
    int waited;
    calc_expected(op, a, b, drv_exp, drv_rise, drv_special);
    div_type_i  = op;
    dividend_i  = a;
    divisor_i   = b;
    div_valid_i = 1'b1;
    @(posedge clk);
    #1;
    div_valid_i = 1'b0;
    dividend_i  = {$urandom, $urandom};  // only the accepting cycle counts
    divisor_i   = {$urandom, $urandom};
    if (poke_busy && !drv_special) begin
      div_type_i  = OP_DIVU;  // must be ignored while busy
      div_valid_i = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      div_valid_i = 1'b0;
    end
    waited = 0;
    while (!result_ok_o && waited < RESULT_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!result_ok_o) begin
      $display("no result_ok_o within %0d cycles of the request at time %0t",
               RESULT_TIMEOUT, $time);
      timeout_cnt++;
    end
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    result_ready_i = 1'b1;
    @(posedge clk);
    #1;
    result_ready_i = 1'b0;
    op_cnt++;
  endtask

  task automatic report_test(input string name, input int ops_before, input int errs_before);
    test_cnt++;
    $display("test %s: %0d operations, %0d errors", name, op_cnt - ops_before,
             error_total() - errs_before);
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin
    int    n0;
    int    e0;
    int    k;
    xlen_t a;
    xlen_t b;
    void'($urandom(32'hb106));
    clk         = 1'b0;
    div_type_i  = OP_DIV;
    dividend_i  = '0;
    divisor_i   = '0;
    drv_exp     = '0;
    drv_rise    = 0;
    drv_special = 1'b0;
    apply_reset();

    n0 = op_cnt;
    e0 = error_total();
    for (int i = 0; i < N_D; i++)
      run_op(pick_op($urandom % 4), rand_operand(1'b0), rand_operand(1'b0), 0, 1'b0);
    report_test("random_64", n0, e0);

    n0 = op_cnt;
    e0 = error_total();
    for (int i = 0; i < N_W; i++)
      run_op(pick_op(4 + $urandom % 4), rand_operand(1'b1), rand_operand(1'b1), 0, 1'b0);
    report_test("random_word", n0, e0);

    // zero divisor with garbage above bit 31 for word ops
    n0 = op_cnt;
    e0 = error_total();
    for (int i = 0; i < 8; i++) begin
      b = (i >= 4) ? {$urandom, 32'b0} : '0;
      run_op(pick_op(i), rand_operand(1'b0), b, 0, 1'b0);
    end
    report_test("zero_divisor", n0, e0);

    n0 = op_cnt;
    e0 = error_total();
    for (int i = 0; i < 4; i++) begin
      if (i < 2) begin
        a = 64'h8000_0000_0000_0000;
        b = '1;
      end else begin
        a = {$urandom, 32'h8000_0000};
        b = {$urandom, 32'hffff_ffff};
      end
      run_op(pick_op(2 * i), a, b, 0, 1'b0);  // div, rem, divw, remw
    end
    report_test("overflow", n0, e0);

    n0 = op_cnt;
    e0 = error_total();
    for (int i = 0; i < N_BP; i++) begin
      k = $urandom % 8;
      run_op(pick_op(k), rand_operand(k >= 4), rand_operand(k >= 4), $urandom % 11,
             i < N_BP / 2);
    end
    report_test("back_pressure", n0, e0);

    // reset in the middle of a division
    n0 = op_cnt;
    e0 = error_total();
    a  = rand_operand(1'b0);
    calc_expected(OP_DIVU, a, 64'd7, drv_exp, drv_rise, drv_special);
    div_type_i  = OP_DIVU;
    dividend_i  = a;
    divisor_i   = 64'd7;
    div_valid_i = 1'b1;
    @(posedge clk);
    #1;
    div_valid_i = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    apply_reset();
    op_cnt++;
    run_op(OP_REM, rand_operand(1'b0), rand_operand(1'b0), 1, 1'b0);
    report_test("reset_abort", n0, e0);

    repeat (4) @(posedge clk);
    #1;
    $display("summary: %0d tests, %0d operations, %0d errors", test_cnt, op_cnt,
             error_total());
    if (error_total() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- div_unit.f
div_pkg.sv
div_if.sv
div_prep.sv
div_core.sv
div_result_sel.sv
div_unit.sv
div_unit_chk.sv
div_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module div_unit_tb -f div_unit.f

# keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/Vdiv_unit_tb +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi
